/* compile.f */
source/fetch_types_pkg.sv
source/prefetch_control.sv
source/fetch_bank.sv
source/instruction_aligner.sv
source/fetch_buffer_top.sv
testbench/imem_responder.sv
testbench/fetch_buffer_properties.sv
testbench/fetch_buffer_tb.sv

/* testbench/fetch_buffer_tb.sv */
module fetch_buffer_tb;
  import fetch_types_pkg::*;

  localparam int bank_depth = 4;
  localparam int num_tests = 300;
  localparam int timeout_cycles = 200;

  logic            clock;
  logic            reset;
  fetch_request_t  fetch_request;
  fetch_response_t fetch_response;
  imem_request_t   imem_request;
  logic            imem_ready;
  imem_response_t  imem_response;

  int          error_count;
  int          test_count;
  logic [31:0] core_addr;
  logic [31:0] expected_request;
  int          stale_requests;
  logic [29:0] core_word_held;

  fetch_buffer_top #(
    .bank_depth(bank_depth)
  ) DUT (
    .clock(clock),
    .reset(reset),
    .fetch_request(fetch_request),
    .fetch_response(fetch_response),
    .imem_request(imem_request),
    .imem_ready(imem_ready),
    .imem_response(imem_response)
  );

  imem_responder imem (
    .clock(clock),
    .reset(reset),
    .imem_request(imem_request),
    .imem_ready(imem_ready),
    .imem_response(imem_response)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [15:0] parcel_at(logic [31:0] addr);
    logic [31:0] word;
    word = imem.image[addr[9:2]];
    return addr[1] ? word[31:16] : word[15:0];
  endfunction

  // Memory request order and prefetch distance
  always @(posedge clock) begin
    logic        accept;
    logic [29:0] core_word;
    logic [29:0] ahead;
    accept = imem_request.valid && imem_ready;
    core_word = fetch_request.valid ? fetch_request.addr[31:2] : core_word_held;
    if (!reset) begin
      stale_requests = 0;
      expected_request = '0;
    end else begin
      if (accept && !fetch_request.redirect) begin
        if (stale_requests > 0) begin
          stale_requests--;  // Issued before the redirect
        end else begin
          assert (imem_request.addr == expected_request) else begin
            error_count++;
            $display("MISMATCH prefetch_address expected %h actual %h",
                     expected_request, imem_request.addr);
          end
          ahead = imem_request.addr[31:2] - core_word;
          assert (ahead <= 30'(2 * bank_depth - 1)) else begin
            error_count++;
            $display("prefetch ran %0d words ahead of the core", ahead);
          end
          expected_request = expected_request + 32'd4;
        end
      end
      if (fetch_request.redirect) begin
        stale_requests = (imem_request.valid && !imem_ready) ? 1 : 0;
        expected_request = {fetch_request.addr[31:2], 2'b00};
      end
    end
    if (fetch_request.valid) begin
      core_word_held = fetch_request.addr[31:2];
    end
  end

  task automatic redirect_to(logic [31:0] addr);
    fetch_request.valid = 1'b1;
    fetch_request.redirect = 1'b1;
    fetch_request.addr = addr;
    core_addr = addr;
    @(posedge clock);
    #1;
    fetch_request.redirect = 1'b0;
  endtask

  task automatic idle_core(int cycles);
    fetch_request.valid = 1'b0;
    repeat (cycles) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic fetch_and_check(int index);
    logic [15:0] low_parcel;
    logic [31:0] expected_instr;
    logic        expected_compressed;
    logic        failed;
    string       name;
    int          waited;
    fetch_request.valid = 1'b1;
    fetch_request.redirect = 1'b0;
    fetch_request.addr = core_addr;
    low_parcel = parcel_at(core_addr);
    expected_compressed = low_parcel[1:0] != 2'b11;
    expected_instr = expected_compressed ? {16'h0000, low_parcel}
                                         : {parcel_at(core_addr + 32'd2), low_parcel};
    name = $sformatf("fetch_%0d_at_%h", index, core_addr);
    failed = 1'b0;
    waited = 0;
    @(negedge clock);
    while (!fetch_response.valid) begin
      if (waited == timeout_cycles) begin
        $display("no fetch response for address %h within %0d cycles", core_addr, waited);
        $display("Test FAILED");
        $finish;
      end
      waited++;
      @(negedge clock);
    end
    assert (fetch_response.instr == expected_instr) else begin
      failed = 1'b1;
      $display("MISMATCH %s expected %h actual %h", name, expected_instr,
               fetch_response.instr);
    end
    assert (fetch_response.compressed == expected_compressed) else begin
      failed = 1'b1;
      $display("MISMATCH %s_compressed expected %b actual %b", name, expected_compressed,
               fetch_response.compressed);
    end
    if (failed) begin
      error_count++;
    end
    test_count++;
    $display("%s %s", name, failed ? "failed" : "passed");
    core_addr = core_addr + (expected_compressed ? 32'd2 : 32'd4);
    @(posedge clock);
    #1;
  endtask

  initial begin
    void'($urandom(32'hcd992800));
    imem.fill_image();
    reset = 1'b0;
    fetch_request = '0;
    error_count = 0;
    test_count = 0;
    core_addr = '0;
    core_word_held = '0;
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b1;

    // Quiet until the first redirect even with a request up
    fetch_request.valid = 1'b1;
    fetch_request.addr = {21'd0, 10'($urandom_range(511, 0)), 1'b0};
    repeat (6) begin
      @(negedge clock);
      assert (!imem_request.valid && !fetch_response.valid) else begin
        error_count++;
        $display("request or response raised before the first redirect");
      end
    end
    @(posedge clock);
    #1;

    redirect_to({21'd0, 10'($urandom_range(511, 0)), 1'b0});
    for (int t = 0; t < num_tests; t++) begin
      if ($urandom_range(15, 0) == 0) begin
        redirect_to({21'd0, 10'($urandom_range(511, 0)), 1'b0});
      end else if ($urandom_range(7, 0) == 0) begin
        idle_core($urandom_range(3, 1));
      end
      fetch_and_check(t);
    end

    $display("%0d tests run, %0d errors", test_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* testbench/fetch_buffer_properties.sv */
module fetch_buffer_properties (
  input logic                             clock,
  input logic                             reset,
  input fetch_types_pkg::fetch_request_t  fetch_request,
  input fetch_types_pkg::fetch_response_t fetch_response,
  input fetch_types_pkg::imem_request_t   imem_request,
  input logic                             imem_ready,
  input fetch_types_pkg::imem_response_t  imem_response
);
  import fetch_types_pkg::*;

  logic outstanding;

  always_ff @(posedge clock) begin
    if (!reset) begin
      outstanding <= 1'b0;
    end else if (imem_request.valid && imem_ready) begin
      outstanding <= 1'b1;
    end else if (imem_response.valid) begin
      outstanding <= 1'b0;
    end
  end

  request_held: assert property (@(posedge clock) disable iff (!reset)
    imem_request.valid && !imem_ready |=> imem_request.valid && $stable(imem_request.addr))
    else $error("memory request changed before it was accepted");

  single_outstanding: assert property (@(posedge clock) disable iff (!reset)
    imem_request.valid && imem_ready |-> !outstanding)
    else $error("second memory request accepted while one is outstanding");

  no_response_on_redirect: assert property (@(posedge clock) disable iff (!reset)
    fetch_request.redirect |-> !fetch_response.valid)
    else $error("fetch response raised during a redirect");

endmodule

bind fetch_buffer_top fetch_buffer_properties props (.*);

/* testbench/imem_responder.sv */
module imem_responder (
  input  logic                            clock,
  input  logic                            reset,
  input  fetch_types_pkg::imem_request_t  imem_request,
  output logic                            imem_ready,
  output fetch_types_pkg::imem_response_t imem_response
);
  import fetch_types_pkg::*;

  localparam int image_words = 256;  // Addresses wrap every 1 KB

  logic [31:0] image [image_words];
  logic        busy;
  logic [31:0] held_addr;
  int unsigned wait_cycles;

  // About half the parcels get a compressed opcode
  task automatic fill_image();
    logic [15:0] parcel;
    for (int i = 0; i < image_words; i++) begin
      for (int half = 0; half < 2; half++) begin
        parcel = 16'($urandom);
        if ($urandom_range(1, 0) == 1) begin
          parcel[1:0] = 2'b11;
        end else if (parcel[1:0] == 2'b11) begin
          parcel[1:0] = 2'b01;
        end
        image[i][half*16 +: 16] = parcel;
      end
    end
  endtask

  initial begin
    imem_ready = 1'b0;
    imem_response = '0;
    busy = 1'b0;
    held_addr = '0;
    wait_cycles = 0;
  end

  always begin
    logic        accept;
    logic        in_reset;
    logic [31:0] request_addr;
    @(posedge clock);
    accept = imem_request.valid && imem_ready;
    in_reset = !reset;
    request_addr = imem_request.addr;
    #1;
    imem_response.valid = 1'b0;
    if (in_reset) begin
      busy = 1'b0;
    end else if (accept) begin
      busy = 1'b1;
      held_addr = request_addr;
      wait_cycles = $urandom_range(4, 1);
    end else if (busy) begin
      wait_cycles--;
      if (wait_cycles == 0) begin
        imem_response.valid = 1'b1;
        imem_response.rdata = image[held_addr[9:2]];
        busy = 1'b0;
      end
    end
    // Accepts only when idle and then not in every cycle
    imem_ready = !in_reset && !busy && ($urandom_range(3, 0) != 0);
  end

endmodule

/* source/fetch_buffer_top.sv */
module fetch_buffer_top #(
  parameter int bank_depth = 4
) (
  input  logic                             clock,
  input  logic                             reset,
  input  fetch_types_pkg::fetch_request_t  fetch_request,
  output fetch_types_pkg::fetch_response_t fetch_response,
  output fetch_types_pkg::imem_request_t   imem_request,
  input  logic                             imem_ready,
  input  fetch_types_pkg::imem_response_t  imem_response
);
  import fetch_types_pkg::*;

  bank_write_t              even_write;
  bank_write_t              odd_write;
  bank_lookup_t             even_lookup;
  bank_lookup_t             odd_lookup;
  logic [address_width-1:0] current_word_addr;
  logic [address_width-1:0] next_word_addr;
  logic [address_width-1:0] even_lookup_addr;
  logic [address_width-1:0] odd_lookup_addr;

  assign current_word_addr = {fetch_request.addr[address_width-1:2], 2'b00};
  assign next_word_addr = current_word_addr + address_width'(4);

  // Each bank looks up whichever of the two words it holds
  assign even_lookup_addr = fetch_request.addr[2] ? next_word_addr : current_word_addr;
  assign odd_lookup_addr = fetch_request.addr[2] ? current_word_addr : next_word_addr;

  prefetch_control #(
    .bank_depth(bank_depth)
  ) control (
    .clock(clock),
    .reset(reset),
    .fetch_request(fetch_request),
    .imem_request(imem_request),
    .imem_ready(imem_ready),
    .imem_response(imem_response),
    .even_write(even_write),
    .odd_write(odd_write)
  );

  fetch_bank #(
    .bank_depth(bank_depth)
  ) even_bank (
    .clock(clock),
    .reset(reset),
    .write(even_write),
    .lookup_addr(even_lookup_addr),
    .lookup(even_lookup)
  );

  fetch_bank #(
    .bank_depth(bank_depth)
  ) odd_bank (
    .clock(clock),
    .reset(reset),
    .write(odd_write),
    .lookup_addr(odd_lookup_addr),
    .lookup(odd_lookup)
  );

  instruction_aligner aligner (
    .fetch_request(fetch_request),
    .even_lookup(even_lookup),
    .odd_lookup(odd_lookup),
    .fetch_response(fetch_response)
  );

endmodule

/* source/instruction_aligner.sv */
module instruction_aligner (
  input  fetch_types_pkg::fetch_request_t  fetch_request,
  input  fetch_types_pkg::bank_lookup_t    even_lookup,
  input  fetch_types_pkg::bank_lookup_t    odd_lookup,
  output fetch_types_pkg::fetch_response_t fetch_response
);
  import fetch_types_pkg::*;

  bank_lookup_t current_lookup;
  bank_lookup_t next_lookup;
  fetch_word_u  current_word;
  fetch_word_u  next_word;
  logic [15:0]  first_parcel;
  logic [31:0]  instr;
  logic         compressed;
  logic         parcels_hit;

  // Odd word address puts the current word in the odd bank
  assign current_lookup = fetch_request.addr[2] ? odd_lookup : even_lookup;
  assign next_lookup = fetch_request.addr[2] ? even_lookup : odd_lookup;

  assign current_word = current_lookup.data;
  assign next_word = next_lookup.data;

  assign first_parcel = fetch_request.addr[1] ? current_word.parcel.upper
                                              : current_word.parcel.lower;
  assign compressed = first_parcel[1:0] != 2'b11;

  always_comb begin
    if (compressed) begin
      instr = {16'h0000, first_parcel};
      parcels_hit = current_lookup.hit;
    end else if (fetch_request.addr[1]) begin
      instr = {next_word.parcel.lower, first_parcel};  // Straddles two words
      parcels_hit = current_lookup.hit && next_lookup.hit;
    end else begin
      instr = current_word.word;
      parcels_hit = current_lookup.hit;
    end
  end

  // Never answer in a redirect cycle
  assign fetch_response.valid = fetch_request.valid && !fetch_request.redirect && parcels_hit;
  assign fetch_response.instr = instr;
  assign fetch_response.compressed = compressed;

endmodule

/* source/fetch_bank.sv */
module fetch_bank #(
  parameter int bank_depth = 4
) (
  input  logic                                         clock,
  input  logic                                         reset,
  input  fetch_types_pkg::bank_write_t                 write,
  input  logic [fetch_types_pkg::address_width-1:0]    lookup_addr,
  output fetch_types_pkg::bank_lookup_t                lookup
);
  import fetch_types_pkg::*;

  localparam int index_width = $clog2(bank_depth);
  localparam int tag_width = address_width - 3 - index_width;

  logic [31:0]            data_mem [bank_depth];
  logic [tag_width-1:0]   tag_mem [bank_depth];
  logic [bank_depth-1:0]  valid_bits;

  logic [index_width-1:0] write_index;
  logic [tag_width-1:0]   write_tag;
  logic [index_width-1:0] lookup_index;
  logic [tag_width-1:0]   lookup_tag;

  // Bit 2 selects the bank, so the index starts at bit 3
  assign write_index = write.word_addr[index_width:1];
  assign write_tag = write.word_addr[address_width-3 -: tag_width];
  assign lookup_index = lookup_addr[index_width+2:3];
  assign lookup_tag = lookup_addr[address_width-1 -: tag_width];

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_bits <= '0;
    end else if (write.flush) begin
      valid_bits <= '0;
    end else if (write.wen) begin
      valid_bits[write_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (write.wen) begin
      data_mem[write_index] <= write.data;
      tag_mem[write_index] <= write_tag;
    end
  end

  assign lookup.hit = valid_bits[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
  assign lookup.data = data_mem[lookup_index];

endmodule

/* source/prefetch_control.sv */
module prefetch_control #(
  parameter int bank_depth = 4
) (
  input  logic                            clock,
  input  logic                            reset,
  input  fetch_types_pkg::fetch_request_t fetch_request,
  output fetch_types_pkg::imem_request_t  imem_request,
  input  logic                            imem_ready,
  input  fetch_types_pkg::imem_response_t imem_response,
  output fetch_types_pkg::bank_write_t    even_write,
  output fetch_types_pkg::bank_write_t    odd_write
);
  import fetch_types_pkg::*;

  localparam int word_width = address_width - 2;
  localparam logic [word_width-1:0] ahead_limit = word_width'(2 * bank_depth - 1);

  logic                  started;        // Set by the first redirect
  logic                  request_valid;
  logic                  outstanding;
  logic                  discard;        // Next response predates a redirect
  logic [word_width-1:0] prefetch_word;
  logic [word_width-1:0] request_word;
  logic [word_width-1:0] core_word_held;
  logic [word_width-1:0] core_word;
  logic [word_width-1:0] distance;
  logic                  redirect;
  logic                  response_used;
  logic                  issue;

  assign redirect = fetch_request.redirect;

  // Core position is held while the core has no request up
  assign core_word = fetch_request.valid ? fetch_request.addr[address_width-1:2]
                                         : core_word_held;
  assign distance = prefetch_word - core_word;

  // One request in flight at most; a returning response frees the slot
  assign issue = started && !redirect && !request_valid
                 && (!outstanding || imem_response.valid)
                 && (distance < ahead_limit);

  assign response_used = imem_response.valid && outstanding && !discard && !redirect;

  always_ff @(posedge clock) begin
    if (!reset) begin
      started <= 1'b0;
      request_valid <= 1'b0;
      outstanding <= 1'b0;
      discard <= 1'b0;
    end else begin
      if (redirect) begin
        started <= 1'b1;
      end

      if (issue) begin
        request_valid <= 1'b1;
      end else if (request_valid && imem_ready) begin
        request_valid <= 1'b0;
      end

      if (request_valid && imem_ready) begin
        outstanding <= 1'b1;
      end else if (imem_response.valid) begin
        outstanding <= 1'b0;
      end

      // Anything pending or still in flight belongs to the old stream
      if (redirect) begin
        discard <= request_valid || (outstanding && !imem_response.valid);
      end else if (imem_response.valid) begin
        discard <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (redirect) begin
      prefetch_word <= fetch_request.addr[address_width-1:2];
    end else if (issue) begin
      prefetch_word <= prefetch_word + 1'b1;
    end

    if (issue) begin
      request_word <= prefetch_word;
    end

    if (fetch_request.valid) begin
      core_word_held <= fetch_request.addr[address_width-1:2];
    end
  end

  assign imem_request.valid = request_valid;
  assign imem_request.addr = {request_word, 2'b00};

  // Word address bit 0 picks the bank
  assign even_write.wen = response_used && !request_word[0];
  assign even_write.flush = redirect;
  assign even_write.word_addr = request_word;
  assign even_write.data = imem_response.rdata;

  assign odd_write.wen = response_used && request_word[0];
  assign odd_write.flush = redirect;
  assign odd_write.word_addr = request_word;
  assign odd_write.data = imem_response.rdata;

endmodule

/* source/fetch_types_pkg.sv */
package fetch_types_pkg;

  localparam int address_width = 32;

  // Core to buffer
  typedef struct packed {
    logic                     valid;
    logic                     redirect;
    logic [address_width-1:0] addr;      // Halfword aligned
  } fetch_request_t;

  // Buffer to core
  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
    logic        compressed;
  } fetch_response_t;

  typedef struct packed {
    logic                     valid;
    logic [address_width-1:0] addr;      // Word aligned
  } imem_request_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
  } imem_response_t;

  // Controller to one bank
  typedef struct packed {
    logic                     wen;
    logic                     flush;
    logic [address_width-3:0] word_addr; // Byte address without bits 1..0
    logic [31:0]              data;
  } bank_write_t;

  typedef struct packed {
    logic        hit;
    logic [31:0] data;
  } bank_lookup_t;

  // Fetched word as a whole or as two halfword parcels
  typedef union packed {
    logic [31:0] word;
    struct packed {
      logic [15:0] upper;
      logic [15:0] lower;
    } parcel;
  } fetch_word_u;

endpackage
